//--- px_deser_pkg.sv
package px_deser_pkg;

   // ------------------------------
   // Widths and lane count
   // ------------------------------
   localparam int LANE_BITS      = 8;    // Deserialized word per lane
   localparam int PX_BITS        = 7;    // One pixel, 1:7 serial ratio
   localparam int FIFO_AW        = 5;    // 32-entry ring buffer
   localparam int SEQ_BITS       = 3;    // Gearbox read sequence 0..7
   localparam int NUM_DATA_LANES = 4;    // Data lanes next to the clock lane

   // ------------------------------
   // Basic types
   // ------------------------------
   typedef logic [LANE_BITS-1:0] lane_word_t;
   typedef logic [PX_BITS-1:0]   pixel_t;
   typedef logic [FIFO_AW-1:0]   fifo_addr_t;
   typedef logic [SEQ_BITS-1:0]  gear_seq_t;

   // One input beat from the word side, 41 bits
   typedef struct packed {
      logic                                 word_valid;   // Word strobe, 7 of 8 cycles
      lane_word_t                           clk_word;     // Clock lane
      lane_word_t [NUM_DATA_LANES-1:0]      data_words;   // Data lanes, index = lane
   } rx_words_s;

   // Pixel outputs of all lanes, 35 bits
   typedef struct packed {
      pixel_t                               clk_px;       // Clock lane pixel
      pixel_t [NUM_DATA_LANES-1:0]          data_px;      // Data lane pixels
   } px_out_s;

   // Lane 0 is the clock lane, data lanes follow
   // Word order in the serial stream is LSB first

endpackage

//--- lane_fifo.sv
module lane_fifo (
   input  logic                   px_clk,
   input  logic                   px_rst_n,
   input  logic                   wr_en,      // Delayed word strobe
   input  px_deser_pkg::lane_word_t wr_word,
   input  px_deser_pkg::fifo_addr_t wr_addr,
   input  px_deser_pkg::fifo_addr_t rd_addr,
   output px_deser_pkg::lane_word_t rd_word
);

   localparam int DEPTH = 2 ** px_deser_pkg::FIFO_AW;

   px_deser_pkg::lane_word_t wr_word_q;               // Input word, one cycle late
   px_deser_pkg::lane_word_t mem [DEPTH];             // Ring buffer storage

   // ------------------------------
   // Input word register
   // ------------------------------
   // Captured every cycle; wr_en lines up with the
   // beat that was valid on the previous cycle
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         wr_word_q <= '0;
      end else begin
         wr_word_q <= wr_word;
      end
   end

   // ------------------------------
   // Ring buffer write
   // ------------------------------
   always_ff @(posedge px_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word_q;                   // Same edge as pointer step
      end
   end

   // Asynchronous read, distributed RAM style
   // Gearbox registers the result
   assign rd_word = mem[rd_addr];

endmodule

//--- gearbox_sequencer.sv
module gearbox_sequencer #(
   parameter int WR_START = 16             // Write pointer lead at reset
) (
   input  logic                     px_clk,
   input  logic                     px_rst_n,
   input  logic                     word_valid,
   input  logic                     rd_enable,
   output logic                     wr_en,
   output px_deser_pkg::fifo_addr_t wr_addr,
   output px_deser_pkg::fifo_addr_t rd_addr,
   output px_deser_pkg::gear_seq_t  rd_seq
);

   localparam px_deser_pkg::gear_seq_t SEQ_HOLD = 3'd6;   // Read pointer stalls here

   // ------------------------------
   // Write side
   // ------------------------------
   // Strobe delayed to match the word register in each lane
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         wr_en   <= 1'b0;
         wr_addr <= px_deser_pkg::fifo_addr_t'(WR_START);   // Start ahead of reader
      end else begin
         wr_en <= word_valid;
         if (wr_en) begin
            wr_addr <= wr_addr + px_deser_pkg::fifo_addr_t'(1);
         end
      end
   end

   // ------------------------------
   // Read side
   // ------------------------------
   // 7 reads per 8 cycles, one stall at sequence 6
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         rd_addr <= '0;
      end else if (rd_seq != SEQ_HOLD) begin
         rd_addr <= rd_addr + px_deser_pkg::fifo_addr_t'(1);
      end
   end

   // Sequence holds for one cycle when enable drops
   // That holds every lane back by one bit
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         rd_seq <= '0;
      end else begin
         rd_seq <= rd_seq + px_deser_pkg::gear_seq_t'(rd_enable);   // Wraps 7 to 0
      end
   end

endmodule

//--- gearbox_8to7.sv
module gearbox_8to7 (
   input  logic                     px_clk,
   input  logic                     px_rst_n,
   input  px_deser_pkg::lane_word_t rd_word,   // Current word from the ring buffer
   input  px_deser_pkg::gear_seq_t  rd_seq,
   output px_deser_pkg::pixel_t     px
);

   logic [px_deser_pkg::LANE_BITS-1:1] rd_last;  // Upper bits of previous word

   // ------------------------------
   // Previous word
   // ------------------------------
   // Bit 0 is never taken from the old word
   always_ff @(posedge px_clk) begin
      rd_last <= rd_word[px_deser_pkg::LANE_BITS-1:1];
   end

   // ------------------------------
   // 8-to-7 bit selection
   // ------------------------------
   // Old bits fill the pixel LSBs, new bits the MSBs
   // Sequence n uses n old bits
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         px <= '0;
      end else begin
         case (rd_seq)
            3'd0: begin
               px <= rd_word[6:0];                       // All new
            end
            3'd1: begin
               px <= {rd_word[5:0], rd_last[7]};
            end
            3'd2: begin
               px <= {rd_word[4:0], rd_last[7:6]};
            end
            3'd3: begin
               px <= {rd_word[3:0], rd_last[7:5]};
            end
            3'd4: begin
               px <= {rd_word[2:0], rd_last[7:4]};
            end
            3'd5: begin
               px <= {rd_word[1:0], rd_last[7:3]};
            end
            3'd6: begin
               px <= {rd_word[0], rd_last[7:2]};         // Read pointer stalls next
            end
            default: begin
               px <= rd_last[7:1];                      // Seq 7, all old
            end
         endcase
      end
   end

endmodule

//--- px_align_ctrl.sv
module px_align_ctrl #(
   parameter px_deser_pkg::pixel_t CLK_PATTERN = 7'b1100011,  // Expected clock lane pixel
   parameter int                   GOOD_COUNT  = 8            // Matches in a row to lock
) (
   input  logic                 px_clk,
   input  logic                 locked_and_idlyrdy,   // Async, active low
   input  logic                 rx_ready,             // Training done, async level
   input  px_deser_pkg::pixel_t clk_px,
   output logic                 px_rst_n,
   output logic                 rd_enable,
   output logic                 px_ready
);

   localparam int GOOD_W = $clog2(GOOD_COUNT + 1);
   localparam int SYNC_STAGES = 4;
   localparam logic [2:0] WAIT_LAST = 3'd5;            // 6 wait cycles

   typedef enum logic [1:0] {
      ST_CHECK,
      ST_SLIP_WAIT,
      ST_DONE
   } align_state_e;

   logic [SYNC_STAGES-1:0] rst_sync;
   logic [SYNC_STAGES-1:0] rdy_sync;
   logic                   rx_ready_px;               // rx_ready in px_clk domain
   align_state_e           state;
   logic [2:0]             wait_cnt;
   logic [GOOD_W-1:0]      good_cnt;

   // ------------------------------
   // Reset synchronizer
   // ------------------------------
   // Assert at once, release after 4 edges
   always_ff @(posedge px_clk or negedge locked_and_idlyrdy) begin
      if (!locked_and_idlyrdy) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign px_rst_n = rst_sync[SYNC_STAGES-1];

   // ------------------------------
   // rx_ready synchronizer
   // ------------------------------
   // Cleared directly by the level itself
   always_ff @(posedge px_clk or negedge rx_ready) begin
      if (!rx_ready) begin
         rdy_sync <= '0;
      end else begin
         rdy_sync <= {rdy_sync[SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign rx_ready_px = rdy_sync[SYNC_STAGES-1];

   // ------------------------------
   // Bit-slip FSM
   // ------------------------------
   // Starts in the wait state so the gearbox
   // pipeline fills before the first check
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         state     <= ST_SLIP_WAIT;
         wait_cnt  <= '0;
         good_cnt  <= '0;
         rd_enable <= 1'b0;
      end else if (rx_ready_px) begin               // Frozen until training done
         case (state)
            ST_CHECK: begin
               if (clk_px == CLK_PATTERN) begin
                  rd_enable <= 1'b1;
                  if (good_cnt == GOOD_W'(GOOD_COUNT - 1)) begin
                     state <= ST_DONE;                 // Enough matches in a row
                  end else begin
                     good_cnt <= good_cnt + GOOD_W'(1);
                  end
               end else begin
                  rd_enable <= 1'b0;                  // One-bit slip on all lanes
                  good_cnt  <= '0;
                  wait_cnt  <= '0;
                  state     <= ST_SLIP_WAIT;
               end
            end
            ST_SLIP_WAIT: begin
               // Let the slip reach clk_px
               rd_enable <= 1'b1;
               if (wait_cnt == WAIT_LAST) begin
                  state <= ST_CHECK;
               end else begin
                  wait_cnt <= wait_cnt + 3'd1;
               end
            end
            default: begin
               rd_enable <= 1'b1;                     // ST_DONE, stay until reset
            end
         endcase
      end
   end

   // Ready output, one cycle after the end state
   always_ff @(posedge px_clk or negedge px_rst_n) begin
      if (!px_rst_n) begin
         px_ready <= 1'b0;
      end else begin
         px_ready <= (state == ST_DONE);
      end
   end

endmodule

//--- px_deser_top.sv
module px_deser_top #(
   parameter px_deser_pkg::pixel_t CLK_PATTERN = 7'b1100011,
   parameter int                   WR_START    = 16,
   parameter int                   GOOD_COUNT  = 8
) (
   input  logic                    px_clk,
   input  logic                    locked_and_idlyrdy,   // Async, active low
   input  logic                    rx_ready,             // Training done level
   input  px_deser_pkg::rx_words_s rx_words,
   output px_deser_pkg::px_out_s   px_out,
   output px_deser_pkg::gear_seq_t px_rd_seq,
   output logic                    px_ready
);

   // Clock lane plus data lanes
   localparam int NUM_LANES = px_deser_pkg::NUM_DATA_LANES + 1;

   logic                                     px_rst_n;     // Synchronized reset
   logic                                     rd_enable;
   logic                                     wr_en;
   px_deser_pkg::fifo_addr_t                 wr_addr;
   px_deser_pkg::fifo_addr_t                 rd_addr;
   px_deser_pkg::lane_word_t [NUM_LANES-1:0] lane_in;      // Index 0 is the clock lane
   px_deser_pkg::lane_word_t [NUM_LANES-1:0] lane_rd;
   px_deser_pkg::pixel_t     [NUM_LANES-1:0] lane_px;

   // ------------------------------
   // Lane mapping
   // ------------------------------
   assign lane_in = {rx_words.data_words, rx_words.clk_word};
   assign px_out  = {lane_px[0], lane_px[NUM_LANES-1:1]};  // clk_px is the struct MSB

   // ------------------------------
   // Shared control
   // ------------------------------
   px_align_ctrl #(
      .CLK_PATTERN        (CLK_PATTERN),
      .GOOD_COUNT         (GOOD_COUNT)
   ) i_align_ctrl (
      .px_clk             (px_clk),
      .locked_and_idlyrdy (locked_and_idlyrdy),
      .rx_ready           (rx_ready),
      .clk_px             (lane_px[0]),                   // Watches the clock lane only
      .px_rst_n           (px_rst_n),
      .rd_enable          (rd_enable),
      .px_ready           (px_ready)
   );

   gearbox_sequencer #(
      .WR_START           (WR_START)
   ) i_sequencer (
      .px_clk             (px_clk),
      .px_rst_n           (px_rst_n),
      .word_valid         (rx_words.word_valid),
      .rd_enable          (rd_enable),
      .wr_en              (wr_en),
      .wr_addr            (wr_addr),
      .rd_addr            (rd_addr),
      .rd_seq             (px_rd_seq)
   );

   // ------------------------------
   // Per-lane datapath
   // ------------------------------
   // Same pointers and sequence on every lane, so
   // data lanes keep the clock lane framing
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      lane_fifo i_fifo (
         .px_clk   (px_clk),
         .px_rst_n (px_rst_n),
         .wr_en    (wr_en),
         .wr_word  (lane_in[g]),
         .wr_addr  (wr_addr),
         .rd_addr  (rd_addr),
         .rd_word  (lane_rd[g])
      );

      gearbox_8to7 i_gearbox (
         .px_clk   (px_clk),
         .px_rst_n (px_rst_n),
         .rd_word  (lane_rd[g]),
         .rd_seq   (px_rd_seq),
         .px       (lane_px[g])                         // One cycle after rd_addr
      );
   end

endmodule

//--- tb_px_deser.sv
module tb_px_deser;

   // ------------------------------
   // Test constants
   // ------------------------------
   localparam int                   CLK_HALF      = 20;           // 40 unit period
   localparam px_deser_pkg::pixel_t CLK_PATTERN   = 7'b1100011;
   localparam int                   WR_START      = 16;
   localparam int                   GOOD_COUNT    = 8;
   localparam int                   NUM_DATA      = px_deser_pkg::NUM_DATA_LANES;
   localparam logic [15:0]          SEED          = 16'd6477;
   localparam int                   RESET_CYCLES  = 5;
   localparam int                   QUIET_CYCLES  = 40;           // rx_ready low after reset
   localparam int                   ALIGN_BUDGET  = 160;          // About 20 slips
   localparam int                   CHECK_CYCLES  = 300;          // Locked cycles per run
   localparam int                   SEARCH_DEPTH  = 128;          // Pixels back from newest
   localparam int                   HIST_LEN      = 2048;
   localparam int                   TEST_CYCLES   = 2 * (RESET_CYCLES + QUIET_CYCLES
                                                    + ALIGN_BUDGET + CHECK_CYCLES);
   localparam int                   WATCHDOG_TIME = 3 * TEST_CYCLES * 2 * CLK_HALF;

   logic                    px_clk;
   logic                    locked_and_idlyrdy;
   logic                    rx_ready;
   px_deser_pkg::rx_words_s rx_words;
   px_deser_pkg::px_out_s   px_out;
   px_deser_pkg::gear_seq_t px_rd_seq;
   logic                    px_ready;

   // Stream model state
   logic [15:0]             lfsr;
   logic [15:0]             pend [NUM_DATA+1];    // Unsent bits per lane with clock at 0
   int                      pend_n;               // Same on every lane
   logic [2:0]              beat_cnt;             // Gap beat at 7
   int                      phase;
   px_deser_pkg::pixel_t    hist [NUM_DATA][HIST_LEN];   // Data pixels sent
   int                      hist_cnt;
   int                      exp_idx;              // Next expected data pixel
   logic                    frame_ok;
   int                      value_errors;
   int                      other_errors;
   int                      check_count;

   px_deser_top #(
      .CLK_PATTERN        (CLK_PATTERN),
      .WR_START           (WR_START),
      .GOOD_COUNT         (GOOD_COUNT)
   ) i_dut (
      .px_clk             (px_clk),
      .locked_and_idlyrdy (locked_and_idlyrdy),
      .rx_ready           (rx_ready),
      .rx_words           (rx_words),
      .px_out             (px_out),
      .px_rd_seq          (px_rd_seq),
      .px_ready           (px_ready)
   );

   always #(CLK_HALF) px_clk = ~px_clk;

   // ------------------------------
   // Random bits
   // ------------------------------
   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v[i] = lfsr[0];                          // One step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic compare_values(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         value_errors++;
         $display("FAILED %s at %0t: actual 0x%0h expected 0x%0h",
                  name, $time, actual, expected);
      end
   endtask

   task automatic print_counts();
      $display("Checks %0d, value errors %0d, other errors %0d",
               check_count, value_errors, other_errors);
   endtask

   // ------------------------------
   // Bit-stream model
   // ------------------------------
   // One 7-bit frame on all lanes sent LSB first
   task automatic append_pixel();
      logic [31:0] v;
      int          d;
      pend[0] = pend[0] | (16'(CLK_PATTERN) << pend_n);
      for (d = 0; d < NUM_DATA; d++) begin
         take_bits(px_deser_pkg::PX_BITS, v);
         pend[d+1] = pend[d+1] | (16'(v[6:0]) << pend_n);
         if (hist_cnt < HIST_LEN) begin
            hist[d][hist_cnt] = v[6:0];
         end
      end
      hist_cnt++;
      pend_n += px_deser_pkg::PX_BITS;
   endtask

   // New start phase and a fresh history
   task automatic restart_stream();
      logic [31:0] v;
      int          l;
      v = 32'd7;
      while (v >= 32'd7) begin
         take_bits(3, v);                         // Phase 0..6
      end
      phase = int'(v);
      for (l = 0; l <= NUM_DATA; l++) begin
         pend[l] = '0;
      end
      pend_n   = 0;
      hist_cnt = 0;
      append_pixel();
      for (l = 0; l <= NUM_DATA; l++) begin
         pend[l] = pend[l] >> phase;              // Drop leading bits
      end
      pend_n -= phase;
      $display("Stream restarted with start phase %0d", phase);
   endtask

   // 8-bit words on 7 of 8 beats
   task automatic drive_beat();
      int d;
      int l;
      if (beat_cnt == 3'd7) begin
         rx_words.word_valid = 1'b0;              // Gap for the 7:8 ratio
      end else begin
         while (pend_n < px_deser_pkg::LANE_BITS) begin
            append_pixel();
         end
         rx_words.word_valid = 1'b1;
         rx_words.clk_word   = pend[0][7:0];
         for (d = 0; d < NUM_DATA; d++) begin
            rx_words.data_words[d] = pend[d+1][7:0];
         end
         for (l = 0; l <= NUM_DATA; l++) begin
            pend[l] = pend[l] >> px_deser_pkg::LANE_BITS;
         end
         pend_n -= px_deser_pkg::LANE_BITS;
      end
      beat_cnt = beat_cnt + 3'd1;
   endtask

   // Sample and drive 1 unit after the edge
   task automatic tick();
      @(posedge px_clk);
      #1;
      drive_beat();
   endtask

   // ------------------------------
   // Output checks
   // ------------------------------
   // Frame located by all data lanes at once
   task automatic find_frame();
      int   k;
      int   d;
      int   low;
      logic hit;
      frame_ok = 1'b0;
      low = (hist_cnt > SEARCH_DEPTH) ? hist_cnt - SEARCH_DEPTH : 0;
      k   = ((hist_cnt < HIST_LEN) ? hist_cnt : HIST_LEN) - 1;
      while (k >= low && !frame_ok) begin
         hit = 1'b1;
         for (d = 0; d < NUM_DATA; d++) begin
            if (px_out.data_px[d] !== hist[d][k]) begin
               hit = 1'b0;
            end
         end
         if (hit) begin
            frame_ok = 1'b1;
            exp_idx  = k;                         // Newest match wins
         end
         k--;
      end
      if (!frame_ok) begin
         other_errors++;
         $display("ERROR at %0t: px_ready rose but the data pixels were never sent", $time);
      end
   endtask

   task automatic check_locked_cycle();
      int d;
      compare_values("px_ready", px_ready, 1'b1);
      compare_values("clk_px", px_out.clk_px, CLK_PATTERN);
      if (frame_ok) begin
         if (exp_idx >= hist_cnt || exp_idx >= HIST_LEN) begin
            other_errors++;
            $display("ERROR at %0t: data lanes ran past the last pixel sent", $time);
            frame_ok = 1'b0;
         end else begin
            for (d = 0; d < NUM_DATA; d++) begin
               compare_values($sformatf("data_px[%0d]", d), px_out.data_px[d],
                              hist[d][exp_idx]);
            end
            // Pixel k leaves the gearbox at sequence k + phase
            compare_values("px_rd_seq", px_rd_seq,
                           32'((exp_idx + phase + 1) % 8));   // Sequence already stepped
            exp_idx++;                            // No gaps allowed
         end
      end
   endtask

   // Quiet period then training done and locked checks
   task automatic run_alignment();
      int n;
      rx_ready = 1'b0;
      for (n = 0; n < QUIET_CYCLES; n++) begin
         tick();
         compare_values("px_ready", px_ready, 1'b0);
         compare_values("px_rd_seq", px_rd_seq, 3'd0);   // Held while frozen
      end
      rx_ready = 1'b1;
      n = 0;
      while (px_ready !== 1'b1 && n < ALIGN_BUDGET) begin
         tick();
         n++;
      end
      if (px_ready !== 1'b1) begin
         other_errors++;
         $display("ERROR at %0t: px_ready did not rise within %0d cycles of rx_ready",
                  $time, ALIGN_BUDGET);
      end else begin
         $display("px_ready rose %0d cycles after rx_ready", n);
         find_frame();
         for (n = 0; n < CHECK_CYCLES; n++) begin
            check_locked_cycle();
            tick();
         end
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      px_clk             = 1'b0;
      locked_and_idlyrdy = 1'b0;                 // Reset from time 0
      rx_ready           = 1'b0;
      rx_words           = '0;
      lfsr               = SEED;
      beat_cnt           = '0;
      exp_idx            = 0;
      frame_ok           = 1'b0;
      value_errors       = 0;
      other_errors       = 0;
      check_count        = 0;
      restart_stream();

      repeat (RESET_CYCLES) begin
         tick();
      end
      locked_and_idlyrdy = 1'b1;
      run_alignment();

      // Mid-run reset with training restarted
      locked_and_idlyrdy = 1'b0;
      rx_ready           = 1'b0;
      #1;
      compare_values("px_ready", px_ready, 1'b0);   // Falls without a clock
      restart_stream();
      repeat (RESET_CYCLES) begin
         tick();
      end
      locked_and_idlyrdy = 1'b1;
      run_alignment();

      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Three times the expected run length
   initial begin
      #(WATCHDOG_TIME);
      other_errors++;
      $display("ERROR at %0t: watchdog expired before the run finished", $time);
      print_counts();
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- vlog.f
px_deser_pkg.sv
lane_fifo.sv
gearbox_sequencer.sv
gearbox_8to7.sv
px_align_ctrl.sv
px_deser_top.sv
tb_px_deser.sv

//--- Bender.yml
package:
  name: px_deser

sources:
  # Package first, then leaf modules, then the top level
  - px_deser_pkg.sv
  - lane_fifo.sv
  - gearbox_sequencer.sv
  - gearbox_8to7.sv
  - px_align_ctrl.sv
  - px_deser_top.sv

  # Testbench, top module tb_px_deser
  - target: simulation
    files:
      - tb_px_deser.sv
